/* analogizer_video_pkg.sv */
// Analogizer video path types
`default_nettype none

package analogizer_video_pkg;

	localparam int COLOR_W = 8;       // Core colour depth per channel
	localparam int DAC_W = 6;         // RGB DAC input width
	localparam int MODE_SEL_BITS = 3; // Type bits that pick the mode, bit 3 is a don't-care

	typedef logic [COLOR_W-1:0] color_t;
	typedef logic [DAC_W-1:0] dac_color_t;
	typedef logic [3:0] video_type_t; // Analog video type from the core

	// Source pixel, red in the top byte
	typedef struct packed {
		color_t r;
		color_t g;
		color_t b;
	} rgb_t;

	typedef enum logic [1:0] {
		MODE_RGBS, // Csync on the DAC HS line
		MODE_RGSB, // Csync on the DAC sync pin, sync on green
		MODE_PASS  // Colour off, raw hsync
	} out_mode_e;

	// Border colour some cores leave on during blanking gets cut here
	function automatic color_t blank_gate(input color_t c, input logic blank_n);
		return c & {COLOR_W{blank_n}};
	endfunction

	function automatic dac_color_t to_dac(input color_t c);
		return c[COLOR_W-1 -: DAC_W]; // Six MSBs
	endfunction

endpackage

`default_nettype wire

/* analogizer_cart_pkg.sv */
// Cartridge bank types
`default_nettype none

package analogizer_cart_pkg;

	localparam int BANK_W = 8; // Pins per cartridge bank

	typedef logic [BANK_W-1:0] cart_bank_t;

	// Value on every bank while the adapter is off
	localparam cart_bank_t BANK_INACTIVE = '0;

	// Bank 1 top bits, former SNAC outputs and pixel clock
	localparam int BANK1_SPARE_BITS = 3;

	// Bank 1 low bits carry blue 5..1
	localparam int BANK1_BLUE_BITS = BANK_W - BANK1_SPARE_BITS;

	// Bank 3 layout: red then the two sync lines
	localparam int BANK3_SYNC_BITS = 2;

endpackage

`default_nettype wire

/* pixel_if.sv */
// Registered pixel bus
`default_nettype none
`timescale 1ns/100ps

interface pixel_if;
	import analogizer_video_pkg::*;

	rgb_t rgb;     // Colour, already zero while blanked
	logic hsync;   // Raw horizontal sync
	logic csync;   // Composite sync
	logic blank_n; // Low during blanking

	// Input stage side
	modport src (
		output rgb,
		output hsync,
		output csync,
		output blank_n
	);

	// Format selector side
	modport dst (
		input rgb,
		input hsync,
		input csync,
		input blank_n
	);

endinterface

`default_nettype wire

/* dac_if.sv */
// RGB DAC signal bus
`default_nettype none
`timescale 1ns/100ps

interface dac_if;
	import analogizer_video_pkg::*;

	dac_color_t r;
	dac_color_t g;
	dac_color_t b;
	logic sync_h;  // DAC HS line
	logic sync_v;  // DAC sync pin, also VS line
	logic blank_n; // DAC /BLANK

	modport src (
		output r,
		output g,
		output b,
		output sync_h,
		output sync_v,
		output blank_n
	);

	modport dst (
		input r,
		input g,
		input b,
		input sync_h,
		input sync_v,
		input blank_n
	);

endinterface

`default_nettype wire

/* video_input_stage.sv */
// Video input register stage
`default_nettype none
`timescale 1ns/100ps

module video_input_stage (
	input wire logic video_clk,
	input wire logic i_rst_n,
	input wire analogizer_video_pkg::color_t i_r,
	input wire analogizer_video_pkg::color_t i_g,
	input wire analogizer_video_pkg::color_t i_b,
	input wire logic i_hsync,
	input wire logic i_csync,
	input wire logic i_blank_n,
	pixel_if.src o_pix
);
	import analogizer_video_pkg::*;

	rgb_t rgb_q;    // Gated pixel
	logic hsync_q;
	logic csync_q;
	logic blank_n_q;

	// One register stage, syncs stay aligned with the colour
	always_ff @(posedge video_clk) begin
		if (!i_rst_n) begin
			rgb_q <= '0;
			hsync_q <= 1'b0;
			csync_q <= 1'b0;
			blank_n_q <= 1'b0; // Reads as blanked
		end else begin
			rgb_q.r <= blank_gate(i_r, i_blank_n);
			rgb_q.g <= blank_gate(i_g, i_blank_n);
			rgb_q.b <= blank_gate(i_b, i_blank_n);
			hsync_q <= i_hsync;
			csync_q <= i_csync;
			blank_n_q <= i_blank_n;
		end
	end

	// Onto the pixel bus
	assign o_pix.rgb = rgb_q;
	assign o_pix.hsync = hsync_q;
	assign o_pix.csync = csync_q;
	assign o_pix.blank_n = blank_n_q;

endmodule

`default_nettype wire

/* dac_format_select.sv */
// DAC output format selector
`default_nettype none
`timescale 1ns/100ps

module dac_format_select (
	input wire analogizer_video_pkg::video_type_t i_analog_video_type, // Live, no register
	pixel_if.dst i_pix,
	dac_if.src o_dac
);
	import analogizer_video_pkg::*;

	logic [MODE_SEL_BITS-1:0] mode_sel; // Low type bits
	out_mode_e mode;

	// Bit 3 dropped, so 8 aliases 0 and 9 aliases 1
	assign mode_sel = i_analog_video_type[MODE_SEL_BITS-1:0];

	always_comb begin
		case (mode_sel)
			3'd0: mode = MODE_RGBS;
			3'd1: mode = MODE_RGSB;
			// Former Y/C, YPbPr and scandoubler codes
			default: mode = MODE_PASS;
		endcase
	end

	always_comb begin
		// Colour cut to DAC width, blank already applied upstream
		o_dac.r = to_dac(i_pix.rgb.r);
		o_dac.g = to_dac(i_pix.rgb.g);
		o_dac.b = to_dac(i_pix.rgb.b);
		o_dac.blank_n = i_pix.blank_n; // Same in every mode
		case (mode)
			MODE_RGBS: begin
				o_dac.sync_h = i_pix.csync; // Csync out the HS pin
				o_dac.sync_v = 1'b1;
			end
			MODE_RGSB: begin
				// Sync on green, SOG switch on the adapter set to ON
				o_dac.sync_h = 1'b1;
				o_dac.sync_v = i_pix.csync;
			end
			default: begin // Pass-through
				o_dac.r = '0;
				o_dac.g = '0;
				o_dac.b = '0;
				o_dac.sync_h = i_pix.hsync;
				o_dac.sync_v = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

/* cart_port_driver.sv */
// Cartridge port bank driver
`default_nettype none
`timescale 1ns/100ps

module cart_port_driver (
	input wire logic i_rst_n,
	input wire logic i_ena,
	dac_if.dst i_dac,
	output analogizer_cart_pkg::cart_bank_t o_bank1,
	output analogizer_cart_pkg::cart_bank_t o_bank2,
	output analogizer_cart_pkg::cart_bank_t o_bank3,
	output logic o_bank1_dir,
	output logic o_bank2_dir,
	output logic o_bank3_dir
);
	import analogizer_cart_pkg::*;

	logic drive_en; // Adapter owns the pins
	logic [BANK3_SYNC_BITS-1:0] sync_pair;
	logic [BANK1_BLUE_BITS-1:0] blue_hi;
	cart_bank_t bank1_pk;
	cart_bank_t bank2_pk;
	cart_bank_t bank3_pk;

	assign drive_en = i_rst_n & i_ena;

	assign sync_pair = {i_dac.sync_h, i_dac.sync_v}; // HS on bit 1, VS/sync on bit 0
	assign blue_hi = i_dac.b[5:1];

	// Pinout, MSB first
	assign bank3_pk = {i_dac.r, sync_pair};
	assign bank2_pk = {i_dac.b[0], i_dac.blank_n, i_dac.g}; // B0, /BLK, G5..G0
	// Top three pins unused here, pixel clock goes out through the board wrapper
	assign bank1_pk = {{BANK1_SPARE_BITS{1'b0}}, blue_hi};

	// Banks read as inputs while off
	assign o_bank1 = drive_en ? bank1_pk : BANK_INACTIVE;
	assign o_bank2 = drive_en ? bank2_pk : BANK_INACTIVE;
	assign o_bank3 = drive_en ? bank3_pk : BANK_INACTIVE;

	assign o_bank1_dir = drive_en; // 1 drives out
	assign o_bank2_dir = drive_en;
	assign o_bank3_dir = drive_en;

endmodule

`default_nettype wire

/* analogizer_top.sv */
// Analogizer analog video top
`default_nettype none
`timescale 1ns/100ps

module analogizer_top (
	input wire logic video_clk,
	input wire logic i_rst_n,
	input wire logic i_ena, // Adapter enable
	input wire analogizer_video_pkg::video_type_t i_analog_video_type,
	input wire analogizer_video_pkg::color_t i_r,
	input wire analogizer_video_pkg::color_t i_g,
	input wire analogizer_video_pkg::color_t i_b,
	input wire logic i_hsync,
	input wire logic i_vsync, // Part of the core video bus, no kept mode reads it
	input wire logic i_csync,
	input wire logic i_blank_n,
	output analogizer_cart_pkg::cart_bank_t o_cart_bank1,
	output analogizer_cart_pkg::cart_bank_t o_cart_bank2,
	output analogizer_cart_pkg::cart_bank_t o_cart_bank3,
	output logic o_cart_bank1_dir,
	output logic o_cart_bank2_dir,
	output logic o_cart_bank3_dir
);

	pixel_if pix_bus ();
	dac_if dac_bus ();

	// Registered, blank-gated pixel
	video_input_stage u_input (
		.video_clk (video_clk),
		.i_rst_n   (i_rst_n),
		.i_r       (i_r),
		.i_g       (i_g),
		.i_b       (i_b),
		.i_hsync   (i_hsync),
		.i_csync   (i_csync),
		.i_blank_n (i_blank_n),
		.o_pix     (pix_bus.src)
	);

	// Mode decode, zero latency
	dac_format_select u_format (
		.i_analog_video_type (i_analog_video_type),
		.i_pix               (pix_bus.dst),
		.o_dac               (dac_bus.src)
	);

	cart_port_driver u_cart (
		.i_rst_n     (i_rst_n),
		.i_ena       (i_ena),
		.i_dac       (dac_bus.dst),
		.o_bank1     (o_cart_bank1),
		.o_bank2     (o_cart_bank2),
		.o_bank3     (o_cart_bank3),
		.o_bank1_dir (o_cart_bank1_dir),
		.o_bank2_dir (o_cart_bank2_dir),
		.o_bank3_dir (o_cart_bank3_dir)
	);

endmodule

`default_nettype wire

/* tb_analogizer.sv */
// Analogizer video path testbench
`default_nettype none
`timescale 1ns/100ps

module tb_analogizer;
	import analogizer_video_pkg::*;
	import analogizer_cart_pkg::*;

	localparam int CLK_PERIOD = 4;  // ns
	localparam int RST_CYCLES = 3;
	localparam int BLOCK_LEN = 64;  // Cycles per type and enable setting
	localparam int BLOCKS = 20;     // First 16 walk every type code
	localparam int TOTAL_CYCLES = RST_CYCLES + BLOCKS * BLOCK_LEN;

	logic video_clk;
	logic i_rst_n;
	logic i_ena;
	video_type_t i_analog_video_type;
	color_t i_r;
	color_t i_g;
	color_t i_b;
	logic i_hsync;
	logic i_vsync;
	logic i_csync;
	logic i_blank_n;
	cart_bank_t o_cart_bank1;
	cart_bank_t o_cart_bank2;
	cart_bank_t o_cart_bank3;
	logic o_cart_bank1_dir;
	logic o_cart_bank2_dir;
	logic o_cart_bank3_dir;

	logic [31:0] lcg_state;

	// Model copy of last cycle's pixel
	color_t m_r;
	color_t m_g;
	color_t m_b;
	logic m_hsync;
	logic m_csync;
	logic m_blank_n;

	cart_bank_t exp_bank1;
	cart_bank_t exp_bank2;
	cart_bank_t exp_bank3;
	logic exp_dir; // Same for all three banks

	analogizer_top dut0 (
		.video_clk           (video_clk),
		.i_rst_n             (i_rst_n),
		.i_ena               (i_ena),
		.i_analog_video_type (i_analog_video_type),
		.i_r                 (i_r),
		.i_g                 (i_g),
		.i_b                 (i_b),
		.i_hsync             (i_hsync),
		.i_vsync             (i_vsync),
		.i_csync             (i_csync),
		.i_blank_n           (i_blank_n),
		.o_cart_bank1        (o_cart_bank1),
		.o_cart_bank2        (o_cart_bank2),
		.o_cart_bank3        (o_cart_bank3),
		.o_cart_bank1_dir    (o_cart_bank1_dir),
		.o_cart_bank2_dir    (o_cart_bank2_dir),
		.o_cart_bank3_dir    (o_cart_bank3_dir)
	);

	initial begin
		video_clk = 1'b0;
		forever #(CLK_PERIOD / 2) video_clk = ~video_clk;
	end

	// Numerical Recipes LCG constants
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic stop_on_failure();
		$display("Verification failed");
		$fatal(1, "Run stopped after a failure");
	endtask

	task automatic expect_value(input string name, input logic [7:0] exp, input logic [7:0] act);
		assert (act === exp) else begin
			$display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
				$time, name, exp, act);
			stop_on_failure();
		end
	endtask

	task automatic expect_bit(input string name, input logic exp, input logic act);
		assert (act === exp) else begin
			$display("CHECK FAILED time=%0t signal=%s expected=%b actual=%b",
				$time, name, exp, act);
			stop_on_failure();
		end
	endtask

	// New video every cycle, high bits only since LCG low bits are weak
	task automatic drive_video();
		logic [31:0] a;
		logic [31:0] c;
		a = next_rand();
		c = next_rand();
		i_r = a[31:24];
		i_g = a[23:16];
		i_b = a[15:8];
		i_hsync = c[31];
		i_vsync = c[30];
		i_csync = c[29];
		i_blank_n = (c[28:27] != 2'b00); // Mostly visible
	endtask

	task automatic pick_block(input int k);
		logic [31:0] r;
		r = next_rand();
		if (k < 16) begin
			i_analog_video_type = video_type_t'(k);
			i_ena = (k % 5 != 2); // Block 2 off, block 3 back on
		end else begin
			i_analog_video_type = r[31:28];
			i_ena = r[24];
		end
	endtask

	// Input register as seen from outside
	task automatic update_model();
		if (!i_rst_n) begin
			m_r = '0;
			m_g = '0;
			m_b = '0;
			m_hsync = 1'b0;
			m_csync = 1'b0;
			m_blank_n = 1'b0;
		end else begin
			m_r = i_blank_n ? i_r : 8'h00;
			m_g = i_blank_n ? i_g : 8'h00;
			m_b = i_blank_n ? i_b : 8'h00;
			m_hsync = i_hsync;
			m_csync = i_csync;
			m_blank_n = i_blank_n;
		end
	endtask

	task automatic compute_expected();
		logic [5:0] dr;
		logic [5:0] dg;
		logic [5:0] db;
		logic sh;
		logic sv;
		logic [2:0] sel;
		sel = i_analog_video_type[2:0]; // Bit 3 ignored
		dr = m_r[7:2];
		dg = m_g[7:2];
		db = m_b[7:2];
		if (sel == 3'd0) begin // RGBS
			sh = m_csync;
			sv = 1'b1;
		end else if (sel == 3'd1) begin // RGsB
			sh = 1'b1;
			sv = m_csync;
		end else begin
			dr = 6'd0;
			dg = 6'd0;
			db = 6'd0;
			sh = m_hsync;
			sv = 1'b1;
		end
		if (i_rst_n && i_ena) begin
			exp_bank3 = {dr, sh, sv};
			exp_bank2 = {db[0], m_blank_n, dg};
			exp_bank1 = {3'b000, db[5:1]};
			exp_dir = 1'b1;
		end else begin
			exp_bank3 = BANK_INACTIVE;
			exp_bank2 = BANK_INACTIVE;
			exp_bank1 = BANK_INACTIVE;
			exp_dir = 1'b0;
		end
	endtask

	task automatic check_outputs();
		compute_expected();
		expect_value("o_cart_bank1", exp_bank1, o_cart_bank1);
		expect_value("o_cart_bank2", exp_bank2, o_cart_bank2);
		expect_value("o_cart_bank3", exp_bank3, o_cart_bank3);
		expect_bit("o_cart_bank1_dir", exp_dir, o_cart_bank1_dir);
		expect_bit("o_cart_bank2_dir", exp_dir, o_cart_bank2_dir);
		expect_bit("o_cart_bank3_dir", exp_dir, o_cart_bank3_dir);
	endtask

	initial begin
		lcg_state = 32'h10a2;
		i_rst_n = 1'b0;
		i_ena = 1'b1; // Reset alone must park the banks
		i_analog_video_type = 4'd0;
		i_r = '0;
		i_g = '0;
		i_b = '0;
		i_hsync = 1'b0;
		i_vsync = 1'b0;
		i_csync = 1'b0;
		i_blank_n = 1'b0;
		update_model();
		for (int cyc = 0; cyc < TOTAL_CYCLES; cyc++) begin
			@(negedge video_clk);
			i_rst_n = (cyc >= RST_CYCLES);
			if (cyc >= RST_CYCLES && (cyc - RST_CYCLES) % BLOCK_LEN == 0)
				pick_block((cyc - RST_CYCLES) / BLOCK_LEN);
			drive_video();
			#1;
			check_outputs(); // Type, enable and reset act with no clock
			@(posedge video_clk);
			update_model();
			#1;
			check_outputs(); // Pixel one edge later
		end
		$display("Verification passed");
		$finish;
	end

	// Watchdog, whole run plus a margin
	initial begin
		#(CLK_PERIOD * (RST_CYCLES + BLOCKS * BLOCK_LEN + 20));
		$display("Timeout: the stimulus loop did not finish in time");
		stop_on_failure();
	end

endmodule

`default_nettype wire

/* project.f */
analogizer_video_pkg.sv
analogizer_cart_pkg.sv
pixel_if.sv
dac_if.sv
video_input_stage.sv
dac_format_select.sv
cart_port_driver.sv
analogizer_top.sv
tb_analogizer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the analogizer video testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_analogizer_sim

verilator --binary --timing --assert -f project.f --top-module tb_analogizer \
	--Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
	echo "ERROR: Verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "ERROR: simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Verification passed" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL: pass message not found in $LOG"
	exit 1
fi
